/* pcxt_timing_pkg.sv */
// Rate constants, speed and model enums, config, tick and reset structs, tick count type
package pcxt_timing_pkg;

	////////////////////
	// Rates
	////////////////////

	// System clock, all logic runs here
	localparam logic [31:0] CLOCK_HZ = 32'd50_000_000;
	// Pixel-rate tick, 4x NTSC color burst
	localparam logic [31:0] PIXEL_HZ = 32'd14_318_000;
	// Audio sample enable
	localparam logic [31:0] AUDIO_HZ = 32'd44_100;

	// CPU-rate ticks from system reset release to CPU reset release
	localparam logic [15:0] CPU_RESET_DELAY = 16'd42;

	////////////////////
	// Types
	////////////////////

	// CPU speed selection, pixel tick divided by 3, 2 or 1
	typedef enum logic [1:0] {
		SPEED_4M77 = 2'd0,
		SPEED_7M16 = 2'd1,
		SPEED_14M3 = 2'd2
	} speed_t;

	// Machine model
	typedef enum logic {
		MODEL_PCXT  = 1'b0,
		MODEL_TANDY = 1'b1
	} model_t;

	// Settings from the environment, held as levels
	typedef struct packed {
		speed_t speed;
		model_t model;
		logic   splash_skip;
	} pcxt_config_t;

	// Single-cycle clock enables
	typedef struct packed {
		logic pixel_ce;
		logic cpu_ce;
		logic peripheral_ce;
		logic audio_ce;
	} pcxt_ticks_t;

	// Reset levels, all high after power-on
	typedef struct packed {
		logic sys_reset;
		logic cpu_reset;
		logic splash_active;
	} pcxt_reset_t;

	// Tick count over a measurement window
	typedef logic [31:0] tick_count_t;

endpackage

/* rate_accumulator.sv */
// Fractional phase accumulator giving a single-cycle tick at an average rate
`timescale 1ns/1ns

module rate_accumulator #(
	parameter logic [31:0] RATE_HZ = pcxt_timing_pkg::PIXEL_HZ,
	parameter logic [31:0] REF_HZ  = pcxt_timing_pkg::CLOCK_HZ
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic tick
);

	// Phase always below REF_HZ
	logic [31:0] phase;
	// One spare bit so the sum never wraps
	logic [32:0] phase_next;
	logic [32:0] phase_wrap;

	assign phase_next = {1'b0, phase} + {1'b0, RATE_HZ};
	assign phase_wrap = phase_next - {1'b0, REF_HZ};

	////////////////////
	// Phase and tick
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			phase <= '0;
			tick  <= 1'b0;
		end else if (phase_next >= {1'b0, REF_HZ}) begin
			// Crossed one reference period, keep the remainder
			phase <= phase_wrap[31:0];
			tick  <= 1'b1;
		end else begin
			phase <= phase_next[31:0];
			tick  <= 1'b0;
		end
	end

endmodule

/* tick_divider.sv */
// Divide-by-3, divide-by-2 and peripheral enables derived from the pixel tick
`timescale 1ns/1ns

module tick_divider (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic pixel_tick,
	output logic slow_ce,
	output logic mid_ce,
	output logic fast_ce,
	output logic periph_raw_ce
);

	// Position within a group of three pixel ticks
	logic [1:0] div3_cnt;
	// High on every other pixel tick
	logic       div2_phase;
	// High on every other slow tick
	logic       periph_phase;
	logic       div3_last;

	assign div3_last = (div3_cnt == 2'd2);

	////////////////////
	// Divider state
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			div3_cnt     <= 2'd0;
			div2_phase   <= 1'b0;
			periph_phase <= 1'b0;
		end else if (pixel_tick) begin
			// Only moves on pixel ticks
			if (div3_last) begin
				div3_cnt <= 2'd0;
			end else begin
				div3_cnt <= div3_cnt + 2'd1;
			end
			div2_phase <= ~div2_phase;
			// Slow tick happens this cycle
			if (div3_last) begin
				periph_phase <= ~periph_phase;
			end
		end
	end

	// Enables line up with the pixel tick itself
	// 14.318 MHz
	assign fast_ce = pixel_tick;
	// 7.16 MHz
	assign mid_ce = pixel_tick & div2_phase;
	// 4.77 MHz
	assign slow_ce = pixel_tick & div3_last;
	// 2.385 MHz, every second slow tick
	assign periph_raw_ce = slow_ce & periph_phase;

endmodule

/* reset_sequencer.sv */
// Splash timer, power-on hold counter, CPU reset delay and model latch
`timescale 1ns/1ns

module reset_sequencer #(
	parameter int unsigned POWER_HOLD_CYCLES = 65535,
	parameter int unsigned SPLASH_SECONDS    = 5,
	parameter int unsigned TICKS_PER_SECOND  = pcxt_timing_pkg::CLOCK_HZ
) (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  logic                          reset_request,
	input  pcxt_timing_pkg::pcxt_config_t cfg,
	input  logic                          slow_ce,
	output pcxt_timing_pkg::pcxt_reset_t  resets,
	output pcxt_timing_pkg::model_t       model
);

	import pcxt_timing_pkg::*;

	localparam int unsigned TICK_W = $clog2(TICKS_PER_SECOND + 1);
	localparam int unsigned SEC_W  = $clog2(SPLASH_SECONDS + 1);
	localparam int unsigned HOLD_W = $clog2(POWER_HOLD_CYCLES + 1);

	// Terminal counts
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SECOND - 1);
	localparam logic [SEC_W-1:0]  SEC_LAST  = SEC_W'(SPLASH_SECONDS - 1);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(POWER_HOLD_CYCLES);
	localparam logic [15:0]       CPU_LAST  = CPU_RESET_DELAY - 16'd1;

	logic              splash_active;
	logic              sys_reset;
	logic              cpu_reset;
	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;
	logic [HOLD_W-1:0] hold_cnt;
	logic [15:0]       cpu_delay_cnt;
	logic              splash_end;
	logic              hold_run;

	// Skip ends the splash at once, otherwise on the last tick of the last second
	assign splash_end = cfg.splash_skip | ((sec_cnt == SEC_LAST) & (tick_cnt == TICK_LAST));
	// Hold counter runs once the splash is gone or being skipped
	assign hold_run = sys_reset & (~splash_active | cfg.splash_skip);

	////////////////////
	// Splash and hold
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			sys_reset     <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
			hold_cnt      <= '0;
		end else if (reset_request) begin
			// Same as power-on, just synchronous
			splash_active <= 1'b1;
			sys_reset     <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
			hold_cnt      <= '0;
		end else begin
			if (splash_active) begin
				if (splash_end) begin
					splash_active <= 1'b0;
				end else if (tick_cnt == TICK_LAST) begin
					// One second elapsed
					tick_cnt <= '0;
					sec_cnt  <= sec_cnt + SEC_W'(1);
				end else begin
					tick_cnt <= tick_cnt + TICK_W'(1);
				end
			end
			if (hold_run) begin
				if (hold_cnt == HOLD_LAST) begin
					sys_reset <= 1'b0;
				end else begin
					hold_cnt <= hold_cnt + HOLD_W'(1);
				end
			end
		end
	end

	////////////////////
	// CPU reset delay
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset     <= 1'b1;
			cpu_delay_cnt <= 16'd0;
		end else if (sys_reset || reset_request) begin
			// Rises together with sys_reset on a request
			cpu_reset     <= 1'b1;
			cpu_delay_cnt <= 16'd0;
		end else if (cpu_reset && slow_ce) begin
			// Counted in 4.77 MHz ticks
			if (cpu_delay_cnt == CPU_LAST) begin
				cpu_reset <= 1'b0;
			end else begin
				cpu_delay_cnt <= cpu_delay_cnt + 16'd1;
			end
		end
	end

	// Model follows the setting only while the system is in reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			model <= MODEL_PCXT;
		end else if (sys_reset) begin
			model <= cfg.model;
		end
	end

	assign resets = '{sys_reset: sys_reset, cpu_reset: cpu_reset, splash_active: splash_active};

endmodule

/* cpu_clock_gate.sv */
// Speed latch on bus completion, CPU tick select and reset masking of CPU and peripheral ticks
`timescale 1ns/1ns

module cpu_clock_gate (
	input  logic                    CLK_50M,
	input  logic                    reset_wire,
	input  pcxt_timing_pkg::speed_t speed,
	input  logic                    bus_done,
	input  logic                    cpu_reset,
	input  logic                    slow_ce,
	input  logic                    mid_ce,
	input  logic                    fast_ce,
	input  logic                    periph_raw_ce,
	output logic                    cpu_ce,
	output logic                    peripheral_ce
);

	import pcxt_timing_pkg::*;

	// Speed the CPU is running at right now
	speed_t active_speed;
	logic   speed_ce;

	////////////////////
	// Speed latch
	////////////////////

	// Changing mid-cycle would stretch or cut a bus cycle
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			active_speed <= SPEED_4M77;
		end else if (bus_done || cpu_reset) begin
			active_speed <= speed;
		end
	end

	// Pick the divider tick for the active speed
	always_comb begin
		case (active_speed)
			SPEED_14M3: speed_ce = fast_ce;
			SPEED_7M16: speed_ce = mid_ce;
			// Unused code falls back to 4.77
			default:    speed_ce = slow_ce;
		endcase
	end

	// No CPU or peripheral activity while the CPU is held
	assign cpu_ce        = speed_ce & ~cpu_reset;
	assign peripheral_ce = periph_raw_ce & ~cpu_reset;

endmodule

/* pcxt_timing_top.sv */
// Top level with pixel and audio accumulators, tick divider, reset sequencer and CPU clock gate
`timescale 1ns/1ns

module pcxt_timing_top #(
	parameter int unsigned POWER_HOLD_CYCLES = 65535,
	parameter int unsigned SPLASH_SECONDS    = 5,
	parameter int unsigned TICKS_PER_SECOND  = pcxt_timing_pkg::CLOCK_HZ
) (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  pcxt_timing_pkg::pcxt_config_t cfg,
	input  logic                          reset_request,
	input  logic                          bus_done,
	output pcxt_timing_pkg::pcxt_ticks_t  ticks,
	output pcxt_timing_pkg::pcxt_reset_t  resets,
	output pcxt_timing_pkg::model_t       model
);

	import pcxt_timing_pkg::*;

	logic pixel_tick;
	logic audio_tick;
	logic slow_ce;
	logic mid_ce;
	logic fast_ce;
	logic periph_raw_ce;
	logic cpu_ce;
	logic peripheral_ce;

	////////////////////
	// Rate generators
	////////////////////

	// 14.318 MHz from 50 MHz
	rate_accumulator #(
		.RATE_HZ(PIXEL_HZ),
		.REF_HZ (CLOCK_HZ)
	) pixel_acc (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.tick      (pixel_tick)
	);

	// 44.1 kHz sample enable
	rate_accumulator #(
		.RATE_HZ(AUDIO_HZ),
		.REF_HZ (CLOCK_HZ)
	) audio_acc (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.tick      (audio_tick)
	);

	tick_divider tick_divider_i (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.pixel_tick   (pixel_tick),
		.slow_ce      (slow_ce),
		.mid_ce       (mid_ce),
		.fast_ce      (fast_ce),
		.periph_raw_ce(periph_raw_ce)
	);

	////////////////////
	// Reset and gating
	////////////////////

	reset_sequencer #(
		.POWER_HOLD_CYCLES(POWER_HOLD_CYCLES),
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) reset_sequencer_i (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.reset_request(reset_request),
		.cfg          (cfg),
		.slow_ce      (slow_ce),
		.resets       (resets),
		.model        (model)
	);

	cpu_clock_gate cpu_clock_gate_i (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.speed        (cfg.speed),
		.bus_done     (bus_done),
		.cpu_reset    (resets.cpu_reset),
		.slow_ce      (slow_ce),
		.mid_ce       (mid_ce),
		.fast_ce      (fast_ce),
		.periph_raw_ce(periph_raw_ce),
		.cpu_ce       (cpu_ce),
		.peripheral_ce(peripheral_ce)
	);

	// Pixel tick runs free, the video side never stops
	assign ticks = '{
		pixel_ce:      pixel_tick,
		cpu_ce:        cpu_ce,
		peripheral_ce: peripheral_ce,
		audio_ce:      audio_tick
	};

endmodule

/* pcxt_timing_assert.sv */
// Bound assertions on reset ordering, single-cycle ticks and CPU tick masking
`timescale 1ns/1ns

module pcxt_timing_assert (
	input logic                         CLK_50M,
	input logic                         reset_wire,
	input pcxt_timing_pkg::pcxt_ticks_t ticks,
	input pcxt_timing_pkg::pcxt_reset_t resets
);

	// Failures so far, polled by the testbench
	int unsigned fail_count = 0;

	// CPU held as long as the system is
	sys_holds_cpu: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		resets.sys_reset |-> resets.cpu_reset)
	else begin
		fail_count++;
		$error("cpu_reset low while sys_reset high");
	end

	// No enable high on two cycles in a row
	ticks_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		(ticks & $past(ticks)) == 4'b0000)
	else begin
		fail_count++;
		$error("tick high on two consecutive cycles");
	end

	cpu_ce_masked: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		resets.cpu_reset |-> !ticks.cpu_ce)
	else begin
		fail_count++;
		$error("cpu_ce high during cpu_reset");
	end

endmodule

bind pcxt_timing_top pcxt_timing_assert timing_checks (
	.CLK_50M   (CLK_50M),
	.reset_wire(reset_wire),
	.ticks     (ticks),
	.resets    (resets)
);

/* tb_pcxt_timing.sv */
// Testbench with stimulus file reader, compare tasks, reset chain, rate and model tests, watchdog
`timescale 1ns/1ns

module tb_pcxt_timing;

	import pcxt_timing_pkg::*;

	localparam int unsigned RESET_CYCLES  = 16;
	// Margin per test for reset release and speed settling
	localparam int unsigned SETTLE_CYCLES = 1000;
	localparam logic [31:0] RAND_SEED     = 32'hf806_8c52;

	// One stimulus line, config plus window and expected values
	typedef struct packed {
		pcxt_config_t setting;
		tick_count_t  window;
		tick_count_t  exp_a;
		tick_count_t  exp_b;
		tick_count_t  tol;
	} test_args_t;

	logic         CLK_50M;
	logic         reset_wire;
	logic         reset_request;
	logic         bus_done;
	pcxt_config_t cfg;
	pcxt_ticks_t  ticks;
	pcxt_reset_t  resets;
	model_t       model;

	string       name_q[$];
	string       mode_q[$];
	test_args_t  args_q[$];
	int unsigned error_count = 0;

	pcxt_timing_top #(
		.POWER_HOLD_CYCLES(100),
		.SPLASH_SECONDS   (2),
		.TICKS_PER_SECOND (1000)
	) pcxt_timing_top_i (
		.CLK_50M      (CLK_50M),
		.reset_wire   (reset_wire),
		.cfg          (cfg),
		.reset_request(reset_request),
		.bus_done     (bus_done),
		.ticks        (ticks),
		.resets       (resets),
		.model        (model)
	);

	// 50 MHz
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic halt_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_count(input string test, input string what, input tick_count_t expected,
			input tick_count_t actual, input tick_count_t tol);
		tick_count_t diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if (diff > tol) begin
			halt_run($sformatf("error: %s %s expected %0d (+/-%0d) actual %0d",
				test, what, expected, tol, actual));
		end
	endtask

	task automatic check_resets(input string test, input pcxt_reset_t expected,
			input pcxt_reset_t actual);
		if (actual !== expected) begin
			halt_run($sformatf("error: %s resets expected %b actual %b", test, expected, actual));
		end
	endtask

	task automatic check_model(input string test, input model_t expected, input model_t actual);
		if (actual !== expected) begin
			halt_run($sformatf("error: %s model expected %0d actual %0d", test, expected, actual));
		end
	endtask

	task automatic check_ticks(input string test, input pcxt_ticks_t expected,
			input pcxt_ticks_t actual);
		if (actual !== expected) begin
			halt_run($sformatf("error: %s ticks expected %b actual %b", test, expected, actual));
		end
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////

	// Full power-on reset, outputs checked in its first cycle
	task automatic apply_reset(input string test, input pcxt_config_t setting);
		@(posedge CLK_50M);
		reset_wire    <= 1'b1;
		reset_request <= 1'b0;
		bus_done      <= 1'b0;
		cfg           <= setting;
		@(negedge CLK_50M);
		check_resets(test, 3'b111, resets);
		check_ticks(test, '0, ticks);
		check_model(test, MODEL_PCXT, model);
		repeat (RESET_CYCLES) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	task automatic wait_cpu_release(input string test, input tick_count_t limit);
		tick_count_t cycles;
		cycles = 0;
		do begin
			@(negedge CLK_50M);
			cycles++;
			if (cycles > limit) begin
				halt_run($sformatf("timeout: %s cpu_reset still high after %0d cycles", test, limit));
			end
		end while (resets.cpu_reset);
	endtask

	task automatic pulse_bus_done();
		@(posedge CLK_50M);
		bus_done <= 1'b1;
		@(posedge CLK_50M);
		bus_done <= 1'b0;
	endtask

	// Counts every enable over a window, optional bus_done pulses at random gaps
	task automatic count_ticks(input tick_count_t window, input bit random_bus,
			output tick_count_t cpu_n, output tick_count_t periph_n,
			output tick_count_t audio_n, output tick_count_t pixel_n);
		int unsigned gap;
		cpu_n    = 0;
		periph_n = 0;
		audio_n  = 0;
		pixel_n  = 0;
		gap      = $urandom_range(40, 8);
		repeat (window) begin
			@(posedge CLK_50M);
			if (random_bus && gap == 0) begin
				bus_done <= 1'b1;
				gap = $urandom_range(40, 8);
			end else begin
				bus_done <= 1'b0;
				if (gap != 0) begin
					gap--;
				end
			end
			@(negedge CLK_50M);
			cpu_n    += ticks.cpu_ce;
			periph_n += ticks.peripheral_ce;
			audio_n  += ticks.audio_ce;
			pixel_n  += ticks.pixel_ce;
		end
		@(posedge CLK_50M);
		bus_done <= 1'b0;
	endtask

	////////////////////
	// Tests
	////////////////////

	// Hold length of sys_reset, then slow ticks up to the CPU release
	task automatic run_chain(input string test, input test_args_t args);
		tick_count_t hold;
		tick_count_t slow;
		tick_count_t pix;
		tick_count_t since_slow;
		tick_count_t cycles;
		bit          sys_seen;
		hold       = 0;
		slow       = 0;
		pix        = 0;
		since_slow = 0;
		cycles     = 0;
		sys_seen   = 1'b0;
		apply_reset(test, args.setting);
		@(negedge CLK_50M);
		while (resets.cpu_reset) begin
			cycles++;
			if (cycles > args.window) begin
				halt_run($sformatf("timeout: %s reset chain longer than %0d cycles", test, args.window));
			end
			if (ticks.pixel_ce) begin
				pix++;
			end
			if (resets.sys_reset) begin
				hold++;
			end else begin
				if (!sys_seen) begin
					// Only the CPU left in reset
					check_resets(test, 3'b010, resets);
					sys_seen = 1'b1;
				end
				since_slow++;
				// Every third pixel tick since reset is a 4.77 MHz tick
				if (ticks.pixel_ce && (pix % 3) == 0) begin
					slow++;
					since_slow = 0;
				end
			end
			@(negedge CLK_50M);
		end
		check_count(test, "sys_reset hold cycles", args.exp_a, hold, args.tol);
		check_count(test, "slow ticks to cpu release", args.exp_b, slow, 0);
		check_count(test, "cycles after last slow tick", 0, since_slow, 0);
		check_resets(test, 3'b000, resets);
	endtask

	task automatic run_rate(input string test, input string mode, input test_args_t args);
		tick_count_t cpu_n;
		tick_count_t periph_n;
		tick_count_t audio_n;
		tick_count_t pixel_n;
		@(posedge CLK_50M);
		cfg <= args.setting;
		// Without bus_done the old speed must stay
		if (mode != "nobus") begin
			pulse_bus_done();
		end
		repeat (4) @(posedge CLK_50M);
		count_ticks(args.window, mode == "rate", cpu_n, periph_n, audio_n, pixel_n);
		check_count(test, "cpu_ce count", args.exp_a, cpu_n, args.tol);
		check_count(test, "peripheral_ce count", args.exp_b, periph_n, args.tol);
	endtask

	task automatic run_audio(input string test, input test_args_t args);
		tick_count_t cpu_n;
		tick_count_t periph_n;
		tick_count_t audio_n;
		tick_count_t pixel_n;
		count_ticks(args.window, 1'b0, cpu_n, periph_n, audio_n, pixel_n);
		check_count(test, "audio_ce count", args.exp_a, audio_n, args.tol);
		check_count(test, "pixel_ce count", args.exp_b, pixel_n, args.tol);
	endtask

	// Model taken in reset, held after, retaken on reset_request
	task automatic run_model(input string test, input test_args_t args);
		apply_reset(test, args.setting);
		wait_cpu_release(test, args.window);
		check_model(test, model_t'(args.exp_a[0]), model);
		@(posedge CLK_50M);
		cfg.model <= model_t'(~args.setting.model);
		repeat (args.window) @(posedge CLK_50M);
		@(negedge CLK_50M);
		check_model(test, model_t'(args.exp_a[0]), model);
		@(posedge CLK_50M);
		reset_request <= 1'b1;
		repeat (4) @(posedge CLK_50M);
		@(negedge CLK_50M);
		check_resets(test, 3'b111, resets);
		check_model(test, model_t'(args.exp_b[0]), model);
		@(posedge CLK_50M);
		reset_request <= 1'b0;
		wait_cpu_release(test, args.window);
		check_model(test, model_t'(args.exp_b[0]), model);
	endtask

	task automatic watchdog(input longint unsigned limit_ns);
		#(limit_ns);
		halt_run($sformatf("timeout: run did not finish within %0d ns", limit_ns));
	endtask

	// Bound checks only count, stop here on their first failure
	always @(negedge CLK_50M) begin
		if (pcxt_timing_top_i.timing_checks.fail_count != 0) begin
			halt_run("assertion failed in the bound timing checks");
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int              fd;
		int              n_read;
		string           line;
		string           test;
		string           mode;
		int unsigned     sp;
		int unsigned     md;
		int unsigned     sk;
		int unsigned     win;
		int unsigned     ea;
		int unsigned     eb;
		int unsigned     tl;
		test_args_t      args;
		longint unsigned budget;
		reset_wire    = 1'b1;
		reset_request = 1'b0;
		bus_done      = 1'b0;
		cfg           = '0;
		void'($urandom(RAND_SEED));

		fd = $fopen("pcxt_timing_stimulus.txt", "r");
		if (fd == 0) begin
			halt_run("cannot open pcxt_timing_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			// Blank lines and # lines carry no test
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
				n_read = $sscanf(line, "%s %s %d %d %d %d %d %d %d",
					test, mode, sp, md, sk, win, ea, eb, tl);
				if (n_read != 9) begin
					halt_run({"malformed stimulus line: ", line});
				end
				args.setting.speed       = speed_t'(sp[1:0]);
				args.setting.model       = model_t'(md[0]);
				args.setting.splash_skip = sk[0];
				args.window              = win;
				args.exp_a               = ea;
				args.exp_b               = eb;
				args.tol                 = tl;
				name_q.push_back(test);
				mode_q.push_back(mode);
				args_q.push_back(args);
			end
		end
		$fclose(fd);
		if (name_q.size() == 0) begin
			halt_run("stimulus file holds no tests");
		end

		// Twice the total test length, 20 ns per cycle
		budget = 0;
		foreach (args_q[i]) begin
			budget += longint'(args_q[i].window) + RESET_CYCLES + SETTLE_CYCLES;
		end
		budget = budget * 2 * 20;
		fork
			watchdog(budget);
		join_none

		foreach (name_q[i]) begin
			case (mode_q[i])
				"chain":                run_chain(name_q[i], args_q[i]);
				"rate", "bus", "nobus": run_rate(name_q[i], mode_q[i], args_q[i]);
				"audio":                run_audio(name_q[i], args_q[i]);
				"model":                run_model(name_q[i], args_q[i]);
				default:                halt_run({"unknown test mode: ", mode_q[i]});
			endcase
		end

		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* pcxt_timing_stimulus.txt */
# name mode speed model splash_skip window expected_a expected_b tolerance
# a/b: chain hold/slow ticks, rate cpu_ce/peripheral_ce, model before/after request, audio audio/pixel
chain_skip    chain 0 0 1 3000  101  42    0
splash_hold   chain 0 0 0 5000  2101 42    0
model_tandy   model 0 1 1 2000  1    0     0
rate_4m77     rate  0 0 1 3000  286  143   2
rate_7m16     rate  1 0 1 3000  430  143   2
rate_14m3     rate  2 0 1 3000  859  143   2
speed_no_bus  nobus 0 0 1 3000  859  143   2
speed_bus     bus   0 0 1 3000  286  143   2
audio_rate    audio 0 0 1 50000 44   14318 1

/* compile.f */
pcxt_timing_pkg.sv
rate_accumulator.sv
tick_divider.sv
reset_sequencer.sv
cpu_clock_gate.sv
pcxt_timing_top.sv
pcxt_timing_assert.sv
tb_pcxt_timing.sv
